// ==== common/flight_cfg.svh ====
`ifndef FLIGHT_CFG_SVH
`define FLIGHT_CFG_SVH

// sys_clk cycles in one timing tick, shared by receiver and PWM prescalers
`define RC_TICK_DIV 4

// Pulse width in ticks that stands for a value of 0
`define PULSE_OFFSET_TICKS 16

// Length of one ESC frame in ticks
`define PWM_PERIOD_TICKS 640

// Number of stick frames buffered between receiver and mixer
`define FRAME_FIFO_DEPTH 4

`endif

// ==== common/flight_pkg.sv ====
`default_nettype none

package flight_pkg;

	// One decoded stick position from the receiver, 0 to 255
	typedef logic [7:0] rc_chan_t;

	// One ESC command where 0 is the shortest pulse and 255 the longest
	typedef logic [7:0] motor_rate_t;

	// Four motor commands travelling together from the mixer to the PWM block
	// Element 0 belongs to motor 1 and element 3 to motor 4
	typedef motor_rate_t [3:0] motor_set_t;

	// Neutral position of the yaw, roll and pitch sticks
	localparam rc_chan_t STICK_CENTER = 8'd128;

endpackage

`default_nettype wire

// ==== common/rc_frame_if.sv ====
`timescale 1ns/10ps
`default_nettype none

interface rc_frame_if;

	logic                 valid;    // Frame offered by the source
	logic                 ready;    // Sink can take the frame this cycle
	flight_pkg::rc_chan_t throttle; // Collective stick
	flight_pkg::rc_chan_t yaw;      // Centre is STICK_CENTER
	flight_pkg::rc_chan_t roll;     // Centre is STICK_CENTER
	flight_pkg::rc_chan_t pitch;    // Centre is STICK_CENTER

	modport src (
		output valid,
		output throttle,
		output yaw,
		output roll,
		output pitch,
		input  ready
	);

	modport snk (
		input  valid,
		input  throttle,
		input  yaw,
		input  roll,
		input  pitch,
		output ready
	);

endinterface

`default_nettype wire

// ==== receiver/rc_receiver.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "flight_cfg.svh"

module rc_receiver (
	input  logic    sys_clk,
	input  logic    rst_n,
	input  logic    throttle_pwm,
	input  logic    yaw_pwm,
	input  logic    roll_pwm,
	input  logic    pitch_pwm,
	rc_frame_if.src frame
);

	localparam int TICK_W = $clog2(`RC_TICK_DIV);

	logic [3:0]           pwm_raw;        // Bit 0 throttle, 1 yaw, 2 roll, 3 pitch
	logic [3:0]           sync_1;         // First synchronizer stage
	logic [3:0]           sync_2;         // Second stage, safe to use
	logic [3:0]           level_q;        // Input level seen at the previous tick
	logic [3:0]           fall;           // Falling edge found at this tick
	logic [TICK_W-1:0]    tick_cnt;       // Prescaler for the timing tick
	logic                 tick;           // One cycle pulse every RC_TICK_DIV cycles
	logic [9:0]           width_cnt [4];  // High time of each channel in ticks
	flight_pkg::rc_chan_t chan_val [4];   // Latest decoded value per channel
	logic [3:0]           done;           // Channel has a fresh value since last send
	logic                 send;           // Load the frame registers
	logic                 accepted;       // Frame taken by the FIFO

	assign pwm_raw  = {pitch_pwm, roll_pwm, yaw_pwm, throttle_pwm};
	assign tick     = (tick_cnt == TICK_W'(`RC_TICK_DIV - 1));
	assign fall     = level_q & ~sync_2;
	assign send     = (&done) && !frame.valid; // Only when nothing is pending
	assign accepted = frame.valid && frame.ready;

	// Width minus the offset, limited to the 8 bit stick range
	function automatic flight_pkg::rc_chan_t width_to_val(input logic [9:0] width);
		logic [9:0] excess;
		excess = width - 10'(`PULSE_OFFSET_TICKS);
		if (width < 10'(`PULSE_OFFSET_TICKS)) begin
			return 8'd0; // Short pulses read as zero
		end else if (excess > 10'd255) begin
			return 8'd255; // Long pulses read as full scale
		end
		return excess[7:0];
	endfunction

	always_ff @(posedge sys_clk) begin
		if (!rst_n) begin
			sync_1   <= '0;
			sync_2   <= '0;
			tick_cnt <= '0;
		end else begin
			sync_1   <= pwm_raw;
			sync_2   <= sync_1;
			tick_cnt <= tick ? '0 : tick_cnt + 1'b1;
		end
	end

	// Width counters, edge detection and done flags for all four channels
	always_ff @(posedge sys_clk) begin
		if (!rst_n) begin
			level_q <= '0;
			done    <= '0;
			for (int i = 0; i < 4; i++) begin
				width_cnt[i] <= '0;
			end
		end else begin
			if (send || accepted) begin
				done <= '0; // Start waiting for a full set of fresh pulses
			end
			if (tick) begin
				level_q <= sync_2;
				for (int i = 0; i < 4; i++) begin
					if (sync_2[i]) begin
						if (width_cnt[i] != '1) begin
							width_cnt[i] <= width_cnt[i] + 1'b1; // Saturates at 1023
						end
					end else if (fall[i]) begin
						width_cnt[i] <= '0;
						done[i]      <= 1'b1; // Overrides the clear above
					end
				end
			end
		end
	end

	// Captures keep landing here while a frame is pending
	always_ff @(posedge sys_clk) begin
		for (int i = 0; i < 4; i++) begin
			if (tick && fall[i]) begin
				chan_val[i] <= width_to_val(width_cnt[i]);
			end
		end
	end

	always_ff @(posedge sys_clk) begin
		if (!rst_n) begin
			frame.valid <= 1'b0;
		end else if (send) begin
			frame.valid <= 1'b1; // Rises the cycle after the last falling edge tick
		end else if (frame.ready) begin
			frame.valid <= 1'b0;
		end
	end

	always_ff @(posedge sys_clk) begin
		if (send) begin
			frame.throttle <= chan_val[0];
			frame.yaw      <= chan_val[1];
			frame.roll     <= chan_val[2];
			frame.pitch    <= chan_val[3];
		end
	end

endmodule

`default_nettype wire

// ==== source/frame_fifo.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "flight_cfg.svh"

module frame_fifo (
	input  logic    sys_clk,
	input  logic    rst_n,
	rc_frame_if.snk wr,
	rc_frame_if.src rd
);

	localparam int DEPTH = `FRAME_FIFO_DEPTH;
	localparam int PTR_W = $clog2(DEPTH);
	localparam int CNT_W = $clog2(DEPTH + 1);

	logic [31:0]      mem [DEPTH]; // Throttle in the top byte, pitch in the bottom
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;      // Points at the head entry
	logic [CNT_W-1:0] count;       // Frames currently held
	logic             wr_en;
	logic             rd_en;

	// Wraps explicitly so the depth need not be a power of two
	function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
		return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
	endfunction

	assign wr.ready = (count != CNT_W'(DEPTH)); // Low while full
	assign wr_en    = wr.valid && wr.ready;
	assign rd.valid = (count != '0);
	assign rd_en    = rd.valid && rd.ready;

	assign {rd.throttle, rd.yaw, rd.roll, rd.pitch} = mem[rd_ptr]; // Head straight from storage

	always_ff @(posedge sys_clk) begin
		if (wr_en) begin
			mem[wr_ptr] <= {wr.throttle, wr.yaw, wr.roll, wr.pitch};
		end
	end

	always_ff @(posedge sys_clk) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (wr_en) begin
				wr_ptr <= ptr_inc(wr_ptr);
			end
			if (rd_en) begin
				rd_ptr <= ptr_inc(rd_ptr);
			end
			case ({wr_en, rd_en})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count; // Both or neither leave the level alone
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== mixer/motor_mixer.sv ====
`timescale 1ns/10ps
`default_nettype none

module motor_mixer (
	input  logic                   sys_clk,
	input  logic                   rst_n,
	rc_frame_if.snk                frame,
	output logic                   set_valid,
	input  logic                   set_ready,
	output flight_pkg::motor_set_t set_data
);

	logic signed [10:0]     thr;     // Throttle widened to signed
	logic signed [10:0]     dev_y;   // Yaw offset from centre
	logic signed [10:0]     dev_r;   // Roll offset from centre
	logic signed [10:0]     dev_p;   // Pitch offset from centre
	logic signed [10:0]     mix [4]; // Unclamped motor sums, range -383 to 637
	flight_pkg::motor_set_t mix_sat;
	logic                   accept;

	// Stick distance from centre, -128 to 127
	function automatic logic signed [10:0] deviation(input flight_pkg::rc_chan_t stick);
		return $signed({3'b000, stick}) - $signed({3'b000, flight_pkg::STICK_CENTER});
	endfunction

	function automatic flight_pkg::motor_rate_t saturate(input logic signed [10:0] v);
		if (v < 0) begin
			return 8'd0;
		end else if (v > 11'sd255) begin
			return 8'd255;
		end
		return v[7:0];
	endfunction

	assign thr   = $signed({3'b000, frame.throttle});
	assign dev_y = deviation(frame.yaw);
	assign dev_r = deviation(frame.roll);
	assign dev_p = deviation(frame.pitch);

	// X layout, motors 1 and 3 turn one way and 2 and 4 the other
	assign mix[0] = thr + dev_p + dev_r - dev_y; // Front right
	assign mix[1] = thr + dev_p - dev_r + dev_y; // Front left
	assign mix[2] = thr - dev_p - dev_r - dev_y; // Rear left
	assign mix[3] = thr - dev_p + dev_r + dev_y; // Rear right

	always_comb begin
		for (int i = 0; i < 4; i++) begin
			mix_sat[i] = saturate(mix[i]);
		end
	end

	assign frame.ready = !set_valid || set_ready; // Empty or draining this cycle
	assign accept      = frame.valid && frame.ready;

	always_ff @(posedge sys_clk) begin
		if (!rst_n) begin
			set_valid <= 1'b0;
		end else if (accept) begin
			set_valid <= 1'b1;
		end else if (set_ready) begin
			set_valid <= 1'b0;
		end
	end

	always_ff @(posedge sys_clk) begin
		if (accept) begin
			set_data <= mix_sat;
		end
	end

endmodule

`default_nettype wire

// ==== mixer/pwm_generator.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "flight_cfg.svh"

module pwm_generator (
	input  logic                   sys_clk,
	input  logic                   rst_n,
	input  logic                   set_valid,
	output logic                   set_ready,
	input  flight_pkg::motor_set_t set_data,
	output logic                   motor_1_pwm,
	output logic                   motor_2_pwm,
	output logic                   motor_3_pwm,
	output logic                   motor_4_pwm
);

	localparam int TICK_W = $clog2(`RC_TICK_DIV);
	localparam int PER_W  = $clog2(`PWM_PERIOD_TICKS);

	logic [TICK_W-1:0]      tick_cnt;     // Own prescaler, same rate as the receiver
	logic                   tick;
	logic [PER_W-1:0]       period_cnt;   // Ticks into the current ESC frame
	logic                   period_start; // Last tick of a frame, counter wraps next
	flight_pkg::motor_set_t active_set;   // Rates used for the running frame
	logic                   loaded;       // A set has arrived since reset
	logic [3:0]             pwm_q;        // Registered pulse outputs

	// Tick count where the pulse of one motor ends
	function automatic logic [PER_W-1:0] high_end(input flight_pkg::motor_rate_t rate);
		return PER_W'(`PULSE_OFFSET_TICKS) + PER_W'(rate);
	endfunction

	assign tick         = (tick_cnt == TICK_W'(`RC_TICK_DIV - 1));
	assign period_start = tick && (period_cnt == PER_W'(`PWM_PERIOD_TICKS - 1));
	assign set_ready    = period_start; // At most one set per frame

	always_ff @(posedge sys_clk) begin
		if (!rst_n) begin
			tick_cnt   <= '0;
			period_cnt <= '0;
		end else begin
			tick_cnt <= tick ? '0 : tick_cnt + 1'b1;
			if (period_start) begin
				period_cnt <= '0;
			end else if (tick) begin
				period_cnt <= period_cnt + 1'b1;
			end
		end
	end

	// A new set only takes effect at a frame boundary so pulses never get cut
	always_ff @(posedge sys_clk) begin
		if (!rst_n) begin
			active_set <= '0;
			loaded     <= 1'b0;
		end else if (period_start && set_valid) begin
			active_set <= set_data;
			loaded     <= 1'b1;
		end
	end

	always_ff @(posedge sys_clk) begin
		if (!rst_n) begin
			pwm_q <= '0;
		end else begin
			for (int i = 0; i < 4; i++) begin
				pwm_q[i] <= loaded && (period_cnt < high_end(active_set[i])); // Silent until first set
			end
		end
	end

	assign motor_1_pwm = pwm_q[0];
	assign motor_2_pwm = pwm_q[1];
	assign motor_3_pwm = pwm_q[2];
	assign motor_4_pwm = pwm_q[3];

endmodule

`default_nettype wire

// ==== source/flight_ctrl_top.sv ====
`timescale 1ns/10ps
`default_nettype none

module flight_ctrl_top (
	input  logic sys_clk,
	input  logic rst_n,
	input  logic throttle_pwm,
	input  logic yaw_pwm,
	input  logic roll_pwm,
	input  logic pitch_pwm,
	output logic motor_1_pwm,
	output logic motor_2_pwm,
	output logic motor_3_pwm,
	output logic motor_4_pwm
);

	rc_frame_if rx_if ();  // Receiver into the FIFO
	rc_frame_if mix_if (); // FIFO into the mixer

	logic                   set_valid; // Mixer has a motor set waiting
	logic                   set_ready; // Generator is at a frame boundary
	flight_pkg::motor_set_t set_data;

	rc_receiver rc_receiver (
		.sys_clk      (sys_clk),
		.rst_n        (rst_n),
		.throttle_pwm (throttle_pwm),
		.yaw_pwm      (yaw_pwm),
		.roll_pwm     (roll_pwm),
		.pitch_pwm    (pitch_pwm),
		.frame        (rx_if.src)
	);

	frame_fifo frame_fifo (
		.sys_clk (sys_clk),
		.rst_n   (rst_n),
		.wr      (rx_if.snk),
		.rd      (mix_if.src)
	);

	motor_mixer motor_mixer (
		.sys_clk   (sys_clk),
		.rst_n     (rst_n),
		.frame     (mix_if.snk),
		.set_valid (set_valid),
		.set_ready (set_ready),
		.set_data  (set_data)
	);

	pwm_generator pwm_generator (
		.sys_clk     (sys_clk),
		.rst_n       (rst_n),
		.set_valid   (set_valid),
		.set_ready   (set_ready),
		.set_data    (set_data),
		.motor_1_pwm (motor_1_pwm),
		.motor_2_pwm (motor_2_pwm),
		.motor_3_pwm (motor_3_pwm),
		.motor_4_pwm (motor_4_pwm)
	);

endmodule

`default_nettype wire

// ==== sim/flight_ctrl_asserts.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "flight_cfg.svh"

module flight_asserts (
	input logic        sys_clk,
	input logic        rst_n,
	input logic        rx_valid,
	input logic        rx_ready,
	input logic [31:0] rx_data,
	input logic        mix_valid,
	input logic        mix_ready,
	input logic [31:0] mix_data,
	input logic [31:0] fifo_count,
	input logic [3:0]  motor_pwm
);

	int fail_cnt = 0; // Read by the testbench at the end of the run

	assert property (@(posedge sys_clk) disable iff (!rst_n)
		rx_valid && !rx_ready |=> rx_valid && $stable(rx_data))
		else begin
			$error("rx_if frame dropped or changed while waiting for ready");
			fail_cnt++;
		end

	assert property (@(posedge sys_clk) disable iff (!rst_n)
		mix_valid && !mix_ready |=> mix_valid && $stable(mix_data))
		else begin
			$error("mix_if frame dropped or changed while waiting for ready");
			fail_cnt++;
		end

	assert property (@(posedge sys_clk) disable iff (!rst_n) fifo_count <= `FRAME_FIFO_DEPTH)
		else begin
			$error("frame FIFO holds more frames than its depth");
			fail_cnt++;
		end

	// Outputs are registered so they clear on the first reset edge
	assert property (@(posedge sys_clk) !rst_n |=> motor_pwm == 4'b0)
		else begin
			$error("motor output high during reset");
			fail_cnt++;
		end

endmodule

bind flight_ctrl_top flight_asserts asserts (
	.sys_clk    (sys_clk),
	.rst_n      (rst_n),
	.rx_valid   (rx_if.valid),
	.rx_ready   (rx_if.ready),
	.rx_data    ({rx_if.throttle, rx_if.yaw, rx_if.roll, rx_if.pitch}),
	.mix_valid  (mix_if.valid),
	.mix_ready  (mix_if.ready),
	.mix_data   ({mix_if.throttle, mix_if.yaw, mix_if.roll, mix_if.pitch}),
	.fifo_count (32'(frame_fifo.count)),
	.motor_pwm  ({motor_4_pwm, motor_3_pwm, motor_2_pwm, motor_1_pwm})
);

`default_nettype wire

// ==== sim/flight_ctrl_tb.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "flight_cfg.svh"

module flight_ctrl_tb;

	localparam int OFS        = `PULSE_OFFSET_TICKS;
	localparam int D          = `RC_TICK_DIV;
	localparam int PER_CYC    = `PWM_PERIOD_TICKS * D; // sys_clk cycles in one ESC frame
	localparam int FRAMES     = 46;                    // Frames sent over all tests
	localparam int TIMEOUT_NS = (FRAMES * 2 + 10) * PER_CYC * 8;

	logic                   sys_clk;
	logic                   rst_n;
	logic                   throttle_pwm;
	logic                   yaw_pwm;
	logic                   roll_pwm;
	logic                   pitch_pwm;
	logic [3:0]             motor_pwm;   // Bit 0 is motor 1
	logic [31:0]            lfsr;
	flight_pkg::motor_set_t exp_q [$];   // Sets the motors should show next, in order
	flight_pkg::motor_set_t meas_q [$];  // Sets measured from the ESC pulses
	flight_pkg::motor_set_t last_pushed;
	int                     err_cnt;
	int                     check_cnt;
	int                     bad_tests;

	flight_ctrl_top uut (
		.sys_clk, .rst_n, .throttle_pwm, .yaw_pwm, .roll_pwm, .pitch_pwm,
		.motor_1_pwm (motor_pwm[0]),
		.motor_2_pwm (motor_pwm[1]),
		.motor_3_pwm (motor_pwm[2]),
		.motor_4_pwm (motor_pwm[3])
	);

	initial begin
		sys_clk = 1'b0;
		forever #4 sys_clk = ~sys_clk; // 8 ns period
	end

	function automatic logic [7:0] rand_byte();
		logic [7:0] b;
		for (int i = 0; i < 8; i++) begin
			lfsr = (lfsr >> 1) ^ (lfsr[0] ? 32'h8020_0003 : 32'h0); // One Galois step per bit
			b    = {b[6:0], lfsr[0]};
		end
		return b;
	endfunction

	// Pulse width in ticks to stick value
	function automatic int decode_width(input int w);
		return (w < OFS) ? 0 : (w - OFS > 255) ? 255 : w - OFS;
	endfunction

	function automatic flight_pkg::motor_set_t mix_ref(input int wt, input int wy,
		input int wr, input int wp);
		int t;
		int y;
		int r;
		int p;
		int m [4];
		flight_pkg::motor_set_t s;
		t = decode_width(wt);
		y = decode_width(wy) - int'(flight_pkg::STICK_CENTER);
		r = decode_width(wr) - int'(flight_pkg::STICK_CENTER);
		p = decode_width(wp) - int'(flight_pkg::STICK_CENTER);
		m = '{t + p + r - y, t + p - r + y, t - p - r - y, t - p + r + y};
		for (int i = 0; i < 4; i++) begin
			s[i] = (m[i] < 0) ? 8'd0 : (m[i] > 255) ? 8'd255 : m[i][7:0];
		end
		return s;
	endfunction

	// Widths are in ticks, all four pulses start on the same edge
	task automatic send_frame(input int wt, input int wy, input int wr, input int wp);
		flight_pkg::motor_set_t s;
		int longest;
		s = mix_ref(wt, wy, wr, wp);
		if (s !== last_pushed) begin
			exp_q.push_back(s); // An identical set would only look like a repeat
			last_pushed = s;
		end
		longest = (wt > wy) ? wt : wy;
		longest = (wr > longest) ? wr : longest;
		longest = (wp > longest) ? wp : longest;
		@(negedge sys_clk);
		{pitch_pwm, roll_pwm, yaw_pwm, throttle_pwm} = 4'hf;
		for (int c = 1; c <= longest * D; c++) begin
			@(negedge sys_clk);
			{pitch_pwm, roll_pwm, yaw_pwm, throttle_pwm} = {c < wp * D, c < wr * D,
				c < wy * D, c < wt * D};
		end
		repeat (20 * D) @(negedge sys_clk); // Low gap before the next frame
	endtask

	task automatic wait_drain();
		while (exp_q.size() != 0) begin
			@(negedge sys_clk); // Watchdog covers a set that never shows up
		end
	endtask

	task automatic report_test(input string name, input int errs_before);
		$display("test %-10s %s", name, (err_cnt == errs_before) ? "ok" : "FAILED");
		if (err_cnt != errs_before) begin
			bad_tests++;
		end
	endtask

	initial begin : measure_pwm
		int hi [4];
		flight_pkg::motor_set_t meas;
		logic busy;
		busy = 1'b0;
		forever begin
			@(negedge sys_clk);
			if (motor_pwm != 4'b0) begin
				if (!busy) begin
					hi = '{0, 0, 0, 0}; // All pulses rise together at a period start
				end
				busy = 1'b1;
				for (int i = 0; i < 4; i++) begin
					hi[i] += motor_pwm[i];
				end
			end else if (busy) begin
				for (int i = 0; i < 4; i++) begin
					meas[i] = 8'(hi[i] / D - OFS); // High ticks back to a rate
				end
				meas_q.push_back(meas);
				busy = 1'b0;
			end
		end
	end

	initial begin : compare_sets
		flight_pkg::motor_set_t meas;
		flight_pkg::motor_set_t last_checked;
		flight_pkg::motor_set_t expected;
		last_checked = 'x;
		forever begin
			@(posedge sys_clk);
			while (meas_q.size() != 0) begin
				meas = meas_q.pop_front();
				if (meas !== last_checked) begin // An unchanged set repeats every period
					last_checked = meas;
					assert (exp_q.size() != 0) else begin
						$display("Motor set %h appeared at %0t with no frame pending", meas, $time);
						err_cnt++;
					end
					if (exp_q.size() != 0) begin
						expected = exp_q.pop_front();
						check_cnt++;
						assert (meas == expected) else begin
							$display("ERR %0t: motor set %h, expected %h", $time, meas, expected);
							err_cnt++;
						end
					end
				end
			end
		end
	end

	initial begin : watchdog
		#(TIMEOUT_NS);
		$display("Timeout: the run did not finish within %0d ns", TIMEOUT_NS);
		$display("Verification failed");
		$finish;
	end

	initial begin : run_tests
		int e0;
		int idle_hi;
		int rw [4];
		time t0;
		lfsr        = 32'hf221_e477;
		last_pushed = 'x;
		err_cnt     = 0;
		check_cnt   = 0;
		bad_tests   = 0;
		rst_n       = 1'b0;
		{pitch_pwm, roll_pwm, yaw_pwm, throttle_pwm} = 4'b0;
		repeat (16) @(negedge sys_clk);
		rst_n = 1'b1;

		e0      = err_cnt;
		idle_hi = 0;
		repeat (PER_CYC) begin
			@(negedge sys_clk);
			idle_hi += (motor_pwm != 4'b0);
		end
		assert (idle_hi == 0) else begin
			$display("ERR %0t: motors pulsed for %0d cycles before any frame was sent",
				$time, idle_hi);
			err_cnt++;
		end
		report_test("idle", e0);

		e0 = err_cnt;
		for (int t = 0; t <= 255; t += 51) begin
			send_frame(OFS + t, OFS + 128, OFS + 128, OFS + 128); // Sticks centred
			wait_drain();
		end
		report_test("throttle", e0);

		e0 = err_cnt;
		for (int n = 0; n < 30; n++) begin
			t0 = $time;
			for (int k = 0; k < 4; k++) begin
				rw[k] = OFS + rand_byte();
			end
			send_frame(rw[0], rw[1], rw[2], rw[3]);
			while ($time - t0 < 2 * PER_CYC * 8) begin
				@(negedge sys_clk); // Two ESC frames apart
			end
		end
		wait_drain();
		report_test("random", e0);

		e0 = err_cnt;
		send_frame(OFS + 255, OFS + 128, OFS + 255, OFS + 128);
		wait_drain();
		send_frame(OFS + 255, OFS + 128, OFS, OFS + 128);
		wait_drain();
		send_frame(OFS, OFS + 128, OFS + 255, OFS + 128);
		wait_drain();
		send_frame(OFS, OFS, OFS, OFS);
		wait_drain();
		report_test("saturate", e0);

		e0 = err_cnt;
		send_frame(5, 300, OFS + 128, OFS + 128); // Below offset and beyond full scale
		wait_drain();
		send_frame(300, 5, 300, 8);
		wait_drain();
		send_frame(8, OFS + 128, OFS + 128, 400);
		wait_drain();
		report_test("clamp", e0);

		e0 = err_cnt;
		send_frame(OFS + 30, OFS + 100, OFS + 150, OFS + 200); // Faster than the ESC frame rate
		send_frame(OFS + 90, OFS + 128, OFS + 60, OFS + 140);
		send_frame(OFS + 180, OFS + 20, OFS + 128, OFS + 128);
		wait_drain();
		report_test("burst", e0);

		$display("Summary: %0d tests failed, %0d set checks, %0d errors, %0d assertion failures",
			bad_tests, check_cnt, err_cnt, uut.asserts.fail_cnt);
		if (err_cnt == 0 && uut.asserts.fail_cnt == 0) begin
			$display("Verification passed");
		end else begin
			$display("Verification failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== sim.f ====
+incdir+common
common/flight_pkg.sv
common/rc_frame_if.sv
receiver/rc_receiver.sv
source/frame_fifo.sv
mixer/motor_mixer.sv
mixer/pwm_generator.sv
source/flight_ctrl_top.sv
sim/flight_ctrl_asserts.sv
sim/flight_ctrl_tb.sv
